// File: design/dcache_pkg.sv
/* Data cache geometry constants, bus transfer type
   and the address decode union */

package dcache_pkg;

  // --------------------------------------------------------------------------
  // Geometry
  // --------------------------------------------------------------------------
  localparam int XLEN           = 32;
  localparam int BLOCK_WORDS    = 4;                          // Words per line
  localparam int SETS           = 16;
  localparam int IDX_BITS       = $clog2(SETS);
  localparam int OFFS_BITS      = $clog2(BLOCK_WORDS);        // Word offset in line
  localparam int TAG_BITS       = XLEN - IDX_BITS - OFFS_BITS - 2;
  localparam int BLK_BITS       = BLOCK_WORDS * XLEN;
  localparam int FLUSH_CNT_BITS = IDX_BITS;                   // One set per count

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------

  // Address word, as a plain value or split into cache fields
  typedef union packed {
    logic [XLEN-1:0] raw;
    struct packed {
      logic [TAG_BITS-1:0]  tag;
      logic [IDX_BITS-1:0]  idx;
      logic [OFFS_BITS-1:0] offs;
      logic [1:0]           byte_offs;                        // Byte within word
    } f;
  } dcache_adr_u;

  typedef enum logic {SINGLE, INCR} biu_type_e;               // Bus transfer type

endpackage

// File: design/dcache_setup.sv
/* Address setup stage: request register and
   read index select for the tag and data arrays */

`timescale 1ns/1ps

module dcache_setup (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            stall_i,
  input  logic                            req_i,
  input  logic                            we_i,
  input  logic [dcache_pkg::XLEN/8-1:0]   be_i,
  input  logic [dcache_pkg::XLEN-1:0]     adr_i,
  input  logic [dcache_pkg::XLEN-1:0]     d_i,
  output logic                            req_o,
  output logic                            we_o,
  output logic [dcache_pkg::XLEN/8-1:0]   be_o,
  output dcache_pkg::dcache_adr_u         adr_o,
  output logic [dcache_pkg::XLEN-1:0]     d_o,
  output logic [dcache_pkg::IDX_BITS-1:0] rd_idx_o
);
  import dcache_pkg::*;

  dcache_adr_u adr_in;                        // Incoming address, decoded
  logic        accept;

  assign adr_in.raw = adr_i;
  assign accept     = req_i & ~stall_i;

  // Valid flag drops while stalled, hit stage works from held payload
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) req_o <= 1'b0;
    else         req_o <= accept;
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_o  <= we_i;
      be_o  <= be_i;
      adr_o <= adr_in;
      d_o   <= d_i;
    end
  end

  // Arrays follow the request that enters the hit stage next
  assign rd_idx_o = accept ? adr_in.f.idx : adr_o.f.idx;

  // Requester keeps a stalled request and its payload in place
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && stall_i |=> req_i && $stable({we_i, be_i, adr_i, d_i}));

endmodule

// File: design/dcache_memory.sv
/* Tag, valid and data arrays per way, tag compare,
   random fill way select and flush invalidate port */

`timescale 1ns/1ps

module dcache_memory #(
  parameter int WAYS = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [dcache_pkg::IDX_BITS-1:0] rd_idx_i,
  input  logic [dcache_pkg::TAG_BITS-1:0] cmp_tag_i,
  input  logic                            filling_i,
  input  logic                            fill_we_i,
  input  logic [dcache_pkg::IDX_BITS-1:0] fill_idx_i,
  input  logic [dcache_pkg::TAG_BITS-1:0] fill_tag_i,
  input  logic [dcache_pkg::BLK_BITS-1:0] fill_line_i,
  input  logic                            st_we_i,
  input  logic [WAYS-1:0]                 st_ways_i,
  input  logic [dcache_pkg::IDX_BITS-1:0] st_idx_i,
  input  logic [dcache_pkg::OFFS_BITS-1:0] st_offs_i,
  input  logic [dcache_pkg::XLEN/8-1:0]   st_be_i,
  input  logic [dcache_pkg::XLEN-1:0]     st_d_i,
  input  logic                            inv_i,
  input  logic [dcache_pkg::IDX_BITS-1:0] inv_idx_i,
  output logic                            hit_o,
  output logic [WAYS-1:0]                 ways_hit_o,
  output logic [dcache_pkg::BLK_BITS-1:0] line_o
);
  import dcache_pkg::*;

  logic [6:0]          way_random;            // Up to 128 ways
  logic [WAYS-1:0]     fill_way;
  logic [BLK_BITS-1:0] way_line [WAYS];       // Line of each way, zero unless hit

  // --------------------------------------------------------------------------
  // Random replacement, frozen while a fill is running
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni)         way_random <= '0;
    else if (!filling_i) way_random <= {way_random[5:0], way_random[6] ~^ way_random[5]};
  end

  if (WAYS == 1) begin : g_direct
    assign fill_way = 1'b1;                   // Direct mapped
  end else begin : g_assoc
    assign fill_way = WAYS'(1) << way_random[$clog2(WAYS)-1:0];
  end

  // --------------------------------------------------------------------------
  // Per way arrays
  // --------------------------------------------------------------------------
  for (genvar w = 0; w < WAYS; w++) begin : g_way
    logic [SETS-1:0]     valid;
    logic [TAG_BITS-1:0] tag_mem [SETS];
    logic [BLK_BITS-1:0] data_mem [SETS];
    logic                valid_q;
    logic [TAG_BITS-1:0] tag_q;
    logic [BLK_BITS-1:0] data_q;

    always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
        valid   <= '0;
        valid_q <= 1'b0;
      end else begin
        valid_q <= valid[rd_idx_i];
        if (inv_i) valid[inv_idx_i] <= 1'b0;
        if (fill_we_i && fill_way[w]) valid[fill_idx_i] <= 1'b1;
      end
    end

    always_ff @(posedge clk_i) begin
      tag_q  <= tag_mem[rd_idx_i];
      data_q <= data_mem[rd_idx_i];
      if (fill_we_i && fill_way[w]) begin
        tag_mem[fill_idx_i]  <= fill_tag_i;
        data_mem[fill_idx_i] <= fill_line_i;
      end else if (st_we_i && st_ways_i[w]) begin
        for (int b = 0; b < XLEN/8; b++) begin
          if (st_be_i[b]) data_mem[st_idx_i][st_offs_i*XLEN + 8*b +: 8] <= st_d_i[8*b +: 8];
        end
      end
    end

    assign ways_hit_o[w] = valid_q & (tag_q == cmp_tag_i);
    assign way_line[w]   = ways_hit_o[w] ? data_q : '0;
  end

  // Hit way line select
  always_comb begin
    line_o = '0;
    for (int w = 0; w < WAYS; w++) begin
      line_o = line_o | way_line[w];
    end
  end

  assign hit_o = |ways_hit_o;

  // Fill only on a miss, so a line lives in one way at most
  assert property (@(posedge clk_i) disable iff (!rst_ni) hit_o |-> $onehot(ways_hit_o));

endmodule

// File: design/dcache_hit.sv
/* Hit stage with the front-end FSM: hit return,
   miss fill, write-through and flush walk */

`timescale 1ns/1ps

module dcache_hit #(
  parameter int WAYS = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  req_i,
  input  logic                                  we_i,
  input  logic [dcache_pkg::XLEN/8-1:0]         be_i,
  input  dcache_pkg::dcache_adr_u               adr_i,
  input  logic [dcache_pkg::XLEN-1:0]           d_i,
  input  logic                                  hit_i,
  input  logic [WAYS-1:0]                       ways_hit_i,
  input  logic [dcache_pkg::BLK_BITS-1:0]       line_i,
  input  logic                                  flush_req_i,
  input  logic                                  cmd_done_i,
  input  logic [dcache_pkg::BLK_BITS-1:0]       fill_line_i,
  output logic                                  stall_o,
  output logic                                  ack_o,
  output logic [dcache_pkg::XLEN-1:0]           q_o,
  output logic                                  flushing_o,
  output logic                                  flush_rdy_o,
  output logic                                  filling_o,
  output logic [dcache_pkg::TAG_BITS-1:0]       cmp_tag_o,
  output logic                                  st_we_o,
  output logic [WAYS-1:0]                       st_ways_o,
  output logic [dcache_pkg::IDX_BITS-1:0]       st_idx_o,
  output logic [dcache_pkg::OFFS_BITS-1:0]      st_offs_o,
  output logic [dcache_pkg::XLEN/8-1:0]         st_be_o,
  output logic [dcache_pkg::XLEN-1:0]           st_d_o,
  output logic                                  fill_we_o,
  output logic [dcache_pkg::IDX_BITS-1:0]       fill_idx_o,
  output logic [dcache_pkg::TAG_BITS-1:0]       fill_tag_o,
  output logic                                  inv_o,
  output logic [dcache_pkg::FLUSH_CNT_BITS-1:0] inv_idx_o,
  output logic                                  cmd_fill_o,
  output logic                                  cmd_write_o,
  output logic [dcache_pkg::XLEN-1:0]           cmd_adr_o,
  output logic [dcache_pkg::XLEN-1:0]           cmd_d_o
);
  import dcache_pkg::*;

  localparam logic [1:0] IDLE  = 2'd0;
  localparam logic [1:0] FILL  = 2'd1;
  localparam logic [1:0] WRITE = 2'd2;
  localparam logic [1:0] FLUSH = 2'd3;

  logic [1:0]                state;
  logic [FLUSH_CNT_BITS-1:0] flush_cnt;
  logic                      idle_req;
  logic [XLEN-1:0]           hit_word, fill_word, merged;

  assign idle_req  = (state == IDLE) & req_i;
  assign hit_word  = line_i[adr_i.f.offs*XLEN +: XLEN];
  assign fill_word = fill_line_i[adr_i.f.offs*XLEN +: XLEN];

  // Store data merged over the cached word, whole word on a miss
  always_comb begin
    merged = hit_i ? hit_word : d_i;
    for (int b = 0; b < XLEN/8; b++) begin
      if (be_i[b]) merged[8*b +: 8] = d_i[8*b +: 8];
    end
  end

  // --------------------------------------------------------------------------
  // Front-end FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state     <= IDLE;
      flush_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          flush_cnt <= '0;                    // Walk restarts at set 0
          if (req_i) begin
            if (we_i)        state <= WRITE;
            else if (!hit_i) state <= FILL;
          end else if (flush_req_i) begin
            state <= FLUSH;
          end
        end
        FILL, WRITE: if (cmd_done_i) state <= IDLE;
        FLUSH: begin
          flush_cnt <= flush_cnt + 1'b1;
          if (flush_cnt == FLUSH_CNT_BITS'(SETS - 1)) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // CPU side
  assign stall_o = (state != IDLE) | (req_i & (we_i | ~hit_i)) | flush_req_i;
  assign ack_o   = (idle_req & ~we_i & hit_i) | ((state == FILL || state == WRITE) & cmd_done_i);
  assign q_o     = (state == FILL) ? fill_word : hit_word;

  assign flushing_o  = (state == FLUSH);
  assign flush_rdy_o = (state != FLUSH) & ~flush_req_i;
  assign filling_o   = (state == FILL);      // Freezes replacement
  assign cmp_tag_o   = adr_i.f.tag;

  // Store hit update
  assign st_we_o   = idle_req & we_i & hit_i;
  assign st_ways_o = ways_hit_i;
  assign st_idx_o  = adr_i.f.idx;
  assign st_offs_o = adr_i.f.offs;
  assign st_be_o   = be_i;
  assign st_d_o    = d_i;

  // Line fill, written as the last beat arrives
  assign fill_we_o  = (state == FILL) & cmd_done_i;
  assign fill_idx_o = adr_i.f.idx;
  assign fill_tag_o = adr_i.f.tag;

  assign inv_o     = (state == FLUSH);
  assign inv_idx_o = flush_cnt;

  // Bus commands
  assign cmd_fill_o  = idle_req & ~we_i & ~hit_i;
  assign cmd_write_o = idle_req & we_i;
  assign cmd_adr_o   = we_i ? {adr_i.raw[XLEN-1:2], 2'b00}
                            : {adr_i.f.tag, adr_i.f.idx, {OFFS_BITS+2{1'b0}}};
  assign cmd_d_o     = merged;

endmodule

// File: design/dcache_biu_ctrl.sv
/* Bus sequencer: strobe phase, data beats,
   fill line assembly and single word writes */

`timescale 1ns/1ps

module dcache_biu_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            cmd_fill_i,
  input  logic                            cmd_write_i,
  input  logic [dcache_pkg::XLEN-1:0]     cmd_adr_i,
  input  logic [dcache_pkg::XLEN-1:0]     cmd_d_i,
  input  logic                            biu_stb_ack_i,
  input  logic                            biu_ack_i,
  input  logic [dcache_pkg::XLEN-1:0]     biu_q_i,
  output logic                            cmd_done_o,
  output logic [dcache_pkg::BLK_BITS-1:0] line_o,
  output logic                            biu_stb_o,
  output logic [dcache_pkg::XLEN-1:0]     biu_adr_o,
  output dcache_pkg::biu_type_e           biu_type_o,
  output logic                            biu_we_o,
  output logic [dcache_pkg::XLEN-1:0]     biu_d_o
);
  import dcache_pkg::*;

  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] STB  = 2'd1;         // Waiting for strobe ack
  localparam logic [1:0] DATA = 2'd2;         // Counting beats

  logic [1:0]           state;
  logic [OFFS_BITS-1:0] beat_cnt;
  logic [BLK_BITS-1:0]  line_buf;
  logic                 start, last_beat;

  assign start      = (state == IDLE) & (cmd_fill_i | cmd_write_i);
  assign last_beat  = biu_we_o | (beat_cnt == OFFS_BITS'(BLOCK_WORDS - 1));
  assign cmd_done_o = (state == DATA) & biu_ack_i & last_beat;
  assign biu_stb_o  = (state == STB);
  assign line_o     = {biu_q_i, line_buf[BLK_BITS-1:XLEN]};  // Last word joins here

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state      <= IDLE;
      beat_cnt   <= '0;
      biu_type_o <= SINGLE;
      biu_we_o   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          beat_cnt <= '0;
          if (start) begin
            state      <= STB;
            biu_we_o   <= cmd_write_i;
            biu_type_o <= cmd_fill_i ? INCR : SINGLE;
          end
        end
        STB: if (biu_stb_ack_i) state <= DATA;
        DATA: begin
          if (biu_ack_i) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address, write data and line buffer
  always_ff @(posedge clk_i) begin
    if (start) begin
      biu_adr_o <= cmd_adr_i;
      biu_d_o   <= cmd_d_i;
    end
    if (state == DATA && biu_ack_i) begin
      line_buf <= {biu_q_i, line_buf[BLK_BITS-1:XLEN]};  // Word 0 ends at the bottom
    end
  end

  // Strobe ack only for a live strobe, beats only in the data phase
  assert property (@(posedge clk_i) disable iff (!rst_ni) biu_stb_ack_i |-> biu_stb_o);
  assert property (@(posedge clk_i) disable iff (!rst_ni) biu_ack_i |-> state == DATA);

endmodule

// File: design/dcache_core.sv
/* Data cache top level: sticky flush request,
   setup and hit stages, arrays and bus controller */

`timescale 1ns/1ps

module dcache_core #(
  parameter int WAYS = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        mem_req_i,
  input  logic                        mem_we_i,
  input  logic [3:0]                  mem_be_i,
  input  logic [dcache_pkg::XLEN-1:0] mem_adr_i,
  input  logic [dcache_pkg::XLEN-1:0] mem_d_i,
  output logic                        stall_o,
  output logic                        mem_ack_o,
  output logic [dcache_pkg::XLEN-1:0] mem_q_o,
  input  logic                        cache_flush_i,
  output logic                        cache_flush_rdy_o,
  output logic                        biu_stb_o,
  input  logic                        biu_stb_ack_i,
  output logic [dcache_pkg::XLEN-1:0] biu_adr_o,
  output dcache_pkg::biu_type_e       biu_type_o,
  output logic                        biu_we_o,
  output logic [dcache_pkg::XLEN-1:0] biu_d_o,
  input  logic                        biu_ack_i,
  input  logic [dcache_pkg::XLEN-1:0] biu_q_i
);
  import dcache_pkg::*;

  logic                      cache_flush, flushing, filling;
  logic                      setup_req, setup_we;
  logic [XLEN/8-1:0]         setup_be;
  dcache_adr_u               setup_adr;
  logic [XLEN-1:0]           setup_d;
  logic [IDX_BITS-1:0]       rd_idx;
  logic                      cache_hit;
  logic [WAYS-1:0]           ways_hit, st_ways;
  logic [BLK_BITS-1:0]       cache_line, biu_line;
  logic [TAG_BITS-1:0]       cmp_tag, fill_tag;
  logic                      st_we, fill_we, inv;
  logic [IDX_BITS-1:0]       st_idx, fill_idx;
  logic [OFFS_BITS-1:0]      st_offs;
  logic [XLEN/8-1:0]         st_be;
  logic [XLEN-1:0]           st_d, cmd_adr, cmd_d;
  logic [FLUSH_CNT_BITS-1:0] inv_idx;
  logic                      cmd_fill, cmd_write, cmd_done;

  // Flush request held until the walk starts
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) cache_flush <= 1'b0;
    else         cache_flush <= cache_flush_i | (cache_flush & ~flushing);
  end

  // --------------------------------------------------------------------------
  // Pipeline
  // --------------------------------------------------------------------------
  dcache_setup setup_inst (
    .clk_i, .rst_ni, .stall_i(stall_o),
    .req_i(mem_req_i), .we_i(mem_we_i), .be_i(mem_be_i), .adr_i(mem_adr_i), .d_i(mem_d_i),
    .req_o(setup_req), .we_o(setup_we), .be_o(setup_be), .adr_o(setup_adr),
    .d_o(setup_d), .rd_idx_o(rd_idx)
  );

  dcache_hit #(.WAYS(WAYS)) hit_inst (
    .clk_i, .rst_ni,
    .req_i(setup_req), .we_i(setup_we), .be_i(setup_be), .adr_i(setup_adr), .d_i(setup_d),
    .hit_i(cache_hit), .ways_hit_i(ways_hit), .line_i(cache_line),
    .flush_req_i(cache_flush), .cmd_done_i(cmd_done), .fill_line_i(biu_line),
    .stall_o, .ack_o(mem_ack_o), .q_o(mem_q_o),
    .flushing_o(flushing), .flush_rdy_o(cache_flush_rdy_o), .filling_o(filling),
    .cmp_tag_o(cmp_tag),
    .st_we_o(st_we), .st_ways_o(st_ways), .st_idx_o(st_idx), .st_offs_o(st_offs),
    .st_be_o(st_be), .st_d_o(st_d),
    .fill_we_o(fill_we), .fill_idx_o(fill_idx), .fill_tag_o(fill_tag),
    .inv_o(inv), .inv_idx_o(inv_idx),
    .cmd_fill_o(cmd_fill), .cmd_write_o(cmd_write), .cmd_adr_o(cmd_adr), .cmd_d_o(cmd_d)
  );

  dcache_memory #(.WAYS(WAYS)) memory_inst (
    .clk_i, .rst_ni, .rd_idx_i(rd_idx), .cmp_tag_i(cmp_tag), .filling_i(filling),
    .fill_we_i(fill_we), .fill_idx_i(fill_idx), .fill_tag_i(fill_tag), .fill_line_i(biu_line),
    .st_we_i(st_we), .st_ways_i(st_ways), .st_idx_i(st_idx), .st_offs_i(st_offs),
    .st_be_i(st_be), .st_d_i(st_d), .inv_i(inv), .inv_idx_i(inv_idx),
    .hit_o(cache_hit), .ways_hit_o(ways_hit), .line_o(cache_line)
  );

  // --------------------------------------------------------------------------
  // Bus side
  // --------------------------------------------------------------------------
  dcache_biu_ctrl biu_ctrl_inst (
    .clk_i, .rst_ni,
    .cmd_fill_i(cmd_fill), .cmd_write_i(cmd_write), .cmd_adr_i(cmd_adr), .cmd_d_i(cmd_d),
    .biu_stb_ack_i, .biu_ack_i, .biu_q_i,
    .cmd_done_o(cmd_done), .line_o(biu_line),
    .biu_stb_o, .biu_adr_o, .biu_type_o, .biu_we_o, .biu_d_o
  );

endmodule

// File: tb/dcache_bus_model.sv
/* Behavioral bus slave: seeded word memory, strobe
   acknowledge, incrementing bursts and single writes */

`timescale 1ns/1ps

module dcache_bus_model #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        stb_i,
  input  logic [dcache_pkg::XLEN-1:0] adr_i,
  input  dcache_pkg::biu_type_e       type_i,
  input  logic                        we_i,
  input  logic [dcache_pkg::XLEN-1:0] d_i,
  output logic                        stb_ack_o,
  output logic                        ack_o,
  output logic [dcache_pkg::XLEN-1:0] q_o
);
  import dcache_pkg::*;

  localparam int AW = $clog2(MEM_WORDS);

  logic [XLEN-1:0] mem [MEM_WORDS];
  int              stb_cnt;                   // Strobes seen so far
  logic [XLEN-1:0] last_adr, last_d;          // Last transfer, for the testbench
  biu_type_e       last_type;
  logic            last_we;
  integer          seed;
  logic [AW-1:0]   widx;
  int              beats;

  initial begin
    seed      = 32'hb4c77592;
    stb_cnt   = 0;
    stb_ack_o = 1'b0;
    ack_o     = 1'b0;
    q_o       = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = $random(seed) ^ (32'(i) << 2);  // Word address folded in
    end
    forever begin
      @(posedge clk_i);
      #1;
      if (rst_ni && stb_i) begin
        stb_cnt   = stb_cnt + 1;
        last_adr  = adr_i;
        last_type = type_i;
        last_we   = we_i;
        last_d    = d_i;
        stb_ack_o = 1'b1;                     // Address phase taken
        @(posedge clk_i);
        #1;
        stb_ack_o = 1'b0;
        beats = (type_i == INCR) ? BLOCK_WORDS : 1;
        widx  = adr_i[AW+1:2];
        for (int k = 0; k < beats; k++) begin
          if (we_i) mem[widx] = d_i;
          ack_o = 1'b1;
          q_o   = mem[widx];
          widx  = widx + 1'b1;                // Burst walks up the line
          @(posedge clk_i);
          #1;
        end
        ack_o = 1'b0;
      end
    end
  end

endmodule

// File: tb/dcache_tb.sv
/* Data cache testbench: clock, reset, bus model,
   reference memory and directed tests */

`timescale 1ns/1ps

module dcache_tb;
  import dcache_pkg::*;

  localparam int WAYS      = 2;
  localparam int TIMEOUT   = 200;             // Cycles per wait
  localparam int MEM_WORDS = 1024;
  localparam int HIT_LAT   = 1;               // Ack in the cycle after the accepting edge

  logic            clk = 1'b0;
  logic            rst_n;
  logic            mem_req, mem_we, stall, mem_ack;
  logic [3:0]      mem_be;
  logic [XLEN-1:0] mem_adr, mem_d, mem_q;
  logic            cache_flush, cache_flush_rdy;
  logic            biu_stb, biu_stb_ack, biu_we, biu_ack;
  logic [XLEN-1:0] biu_adr, biu_d, biu_q;
  biu_type_e       biu_type;

  logic [XLEN-1:0] ref_mem [MEM_WORDS];       // Expected memory contents
  int              val_errors, timeouts;

  always #10 clk = ~clk;

  dcache_core #(.WAYS(WAYS)) dcache_core_inst (
    .clk_i(clk), .rst_ni(rst_n),
    .mem_req_i(mem_req), .mem_we_i(mem_we), .mem_be_i(mem_be), .mem_adr_i(mem_adr),
    .mem_d_i(mem_d), .stall_o(stall), .mem_ack_o(mem_ack), .mem_q_o(mem_q),
    .cache_flush_i(cache_flush), .cache_flush_rdy_o(cache_flush_rdy),
    .biu_stb_o(biu_stb), .biu_stb_ack_i(biu_stb_ack), .biu_adr_o(biu_adr),
    .biu_type_o(biu_type), .biu_we_o(biu_we), .biu_d_o(biu_d),
    .biu_ack_i(biu_ack), .biu_q_i(biu_q)
  );

  dcache_bus_model #(.MEM_WORDS(MEM_WORDS)) bus_model_inst (
    .clk_i(clk), .rst_ni(rst_n), .stb_i(biu_stb), .adr_i(biu_adr), .type_i(biu_type),
    .we_i(biu_we), .d_i(biu_d), .stb_ack_o(biu_stb_ack), .ack_o(biu_ack), .q_o(biu_q)
  );

  // Byte lanes of d replace those of old
  function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] old,
                                                  input logic [XLEN-1:0] d,
                                                  input logic [3:0] be);
    logic [XLEN-1:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) r[8*b +: 8] = d[8*b +: 8];
    end
    return r;
  endfunction

  // --------------------------------------------------------------------------
  // CPU side access
  // --------------------------------------------------------------------------
  task automatic cpu_access(input logic we, input logic [3:0] be, input logic [XLEN-1:0] adr,
                            input logic [XLEN-1:0] d, output logic [XLEN-1:0] q,
                            output int lat);
    int n;
    @(posedge clk);
    #1;
    mem_req = 1'b1;
    mem_we  = we;
    mem_be  = be;
    mem_adr = adr;
    mem_d   = d;
    q       = '0;
    lat     = 0;
    n       = 0;
    @(negedge clk);
    while (stall && n < TIMEOUT) begin        // Held until stall drops
      @(negedge clk);
      n++;
    end
    if (stall) begin
      $display("Timeout: request to %h was never accepted", adr);
      timeouts++;
      mem_req = 1'b0;
    end else begin
      @(posedge clk);                         // Accepting edge
      #1;
      mem_req = 1'b0;
      @(negedge clk);
      lat = 1;
      while (!mem_ack && lat < TIMEOUT) begin
        @(negedge clk);
        lat++;
      end
      if (!mem_ack) begin
        $display("Timeout: no mem_ack_o for access to %h", adr);
        timeouts++;
      end
      q = mem_q;
    end
  endtask

  // Read, compare with reference; exp_stb < 0 skips the strobe count
  task automatic read_check(input logic [XLEN-1:0] adr, input int exp_stb, output int stbs);
    logic [XLEN-1:0] q;
    int              lat, stb0;
    stb0 = bus_model_inst.stb_cnt;
    cpu_access(1'b0, 4'hf, adr, '0, q, lat);
    stbs = bus_model_inst.stb_cnt - stb0;
    if (q !== ref_mem[adr[11:2]]) begin
      $display("ERROR mem_q_o: got %h expected %h at %h", q, ref_mem[adr[11:2]], adr);
      val_errors++;
    end
    if (exp_stb >= 0 && stbs != exp_stb) begin
      $display("ERROR biu_stb_o count: got %h expected %h at %h", stbs, exp_stb, adr);
      val_errors++;
    end
    if (exp_stb == 0 && lat != HIT_LAT) begin
      $display("ERROR hit latency: got %h expected %h at %h", lat, HIT_LAT, adr);
      val_errors++;
    end
    if (stbs > 0 && (bus_model_inst.last_type != INCR || bus_model_inst.last_we !== 1'b0))
    begin
      $display("ERROR biu_type_o/biu_we_o: got %h/%h expected %h/0",
               bus_model_inst.last_type, bus_model_inst.last_we, INCR);
      val_errors++;
    end
    if (stbs > 0 && bus_model_inst.last_adr != {adr[31:4], 4'h0}) begin
      $display("ERROR biu_adr_o: got %h expected %h", bus_model_inst.last_adr,
               {adr[31:4], 4'h0});
      val_errors++;
    end
  endtask

  // Store; exactly one SINGLE write with the merged word
  task automatic write_check(input logic [XLEN-1:0] adr, input logic [3:0] be,
                             input logic [XLEN-1:0] d);
    logic [XLEN-1:0] q, exp;
    int              lat, stb0;
    exp  = merge_bytes(ref_mem[adr[11:2]], d, be);
    stb0 = bus_model_inst.stb_cnt;
    cpu_access(1'b1, be, adr, d, q, lat);
    ref_mem[adr[11:2]] = exp;
    if (bus_model_inst.stb_cnt - stb0 != 1) begin
      $display("ERROR biu_stb_o count: got %h expected 1 at %h", bus_model_inst.stb_cnt - stb0,
               adr);
      val_errors++;
    end
    if (bus_model_inst.last_type != SINGLE || bus_model_inst.last_we !== 1'b1) begin
      $display("ERROR biu_type_o/biu_we_o: got %h/%h expected %h/1",
               bus_model_inst.last_type, bus_model_inst.last_we, SINGLE);
      val_errors++;
    end
    if (bus_model_inst.last_adr != adr) begin
      $display("ERROR biu_adr_o: got %h expected %h", bus_model_inst.last_adr, adr);
      val_errors++;
    end
    if (bus_model_inst.last_d != exp) begin
      $display("ERROR biu_d_o: got %h expected %h", bus_model_inst.last_d, exp);
      val_errors++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic read_miss_test();
    int stbs;
    read_check(32'h0000_0104, 1, stbs);       // Cold line, one burst
  endtask

  task automatic read_hit_test();
    int stbs;
    read_check(32'h0000_0100, 0, stbs);
    read_check(32'h0000_0108, 0, stbs);
    read_check(32'h0000_010c, 0, stbs);
    read_check(32'h0000_0104, 0, stbs);
  endtask

  task automatic write_through_test();
    int stbs;
    write_check(32'h0000_0108, 4'b0110, 32'ha5c3_5a3c);  // Hit, partial word
    read_check(32'h0000_0108, 0, stbs);
    write_check(32'h0000_0204, 4'hf, 32'h1234_5678);     // Miss, no allocate
    read_check(32'h0000_0204, 1, stbs);                  // So this one fills
  endtask

  task automatic replacement_test();
    int stbs, refills;
    refills = 0;
    for (int k = 0; k <= WAYS; k++) begin
      read_check(32'h450 + 32'(k) * 32'h100, 1, stbs);   // All in set 5
    end
    for (int k = 0; k <= WAYS; k++) begin
      read_check(32'h450 + 32'(k) * 32'h100, -1, stbs);
      refills += stbs;
    end
    if (refills == 0) begin
      $display("ERROR refill count: got %h expected nonzero", refills);
      val_errors++;
    end
  endtask

  task automatic flush_test();
    int n, stbs;
    read_check(32'h0000_0104, -1, stbs);
    read_check(32'h0000_0104, 0, stbs);       // Line now resident
    @(posedge clk);
    #1;
    cache_flush = 1'b1;
    @(posedge clk);
    #1;
    cache_flush = 1'b0;
    n = 0;
    @(negedge clk);
    while (cache_flush_rdy && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (cache_flush_rdy) begin
      $display("Timeout: cache_flush_rdy_o never went low");
      timeouts++;
    end
    n = 0;
    while (!cache_flush_rdy && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!cache_flush_rdy) begin
      $display("Timeout: cache_flush_rdy_o stayed low after the flush");
      timeouts++;
    end
    read_check(32'h0000_0104, 1, stbs);       // Refetched after invalidation
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    rst_n       = 1'b0;
    mem_req     = 1'b0;
    mem_we      = 1'b0;
    mem_be      = 4'h0;
    mem_adr     = '0;
    mem_d       = '0;
    cache_flush = 1'b0;
    val_errors  = 0;
    timeouts    = 0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = bus_model_inst.mem[i];     // Start from the model's fill
    end
    @(negedge clk);
    if (stall !== 1'b0 || mem_ack !== 1'b0 || biu_stb !== 1'b0 || cache_flush_rdy !== 1'b1)
    begin
      $display("ERROR reset outputs: stall_o %h mem_ack_o %h biu_stb_o %h flush_rdy %h",
               stall, mem_ack, biu_stb, cache_flush_rdy);
      val_errors++;
    end
    read_miss_test();
    read_hit_test();
    write_through_test();
    replacement_test();
    flush_test();
    $display("Errors: %0d value, %0d timeout", val_errors, timeouts);
    if (val_errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: dcache_core.f
design/dcache_pkg.sv
design/dcache_setup.sv
design/dcache_memory.sv
design/dcache_hit.sv
design/dcache_biu_ctrl.sv
design/dcache_core.sv
tb/dcache_bus_model.sv
tb/dcache_tb.sv

// File: Makefile
# Verilator flow for the data cache core

VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := dcache_tb
FILELIST  := dcache_core.f
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := >>> PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q -F '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
